// ==== all.f ====
src/mesh_pkg.sv
src/path_finder.sv
src/request_arbiter.sv
src/path_allocator.sv
src/mesh_router.sv
src/processing_unit.sv
src/mesh_top.sv
test/mesh_tb.sv

// ==== Makefile ====
# Verilator build and run for the 2x2 mesh testbench
VERILATOR ?= verilator
TOP ?= mesh_tb
FILELIST ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing
PASS_MSG ?= RESULT: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== test/mesh_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// directed testbench for the 2x2 mesh
// each test task starts bursts through the unit configs,
// a monitor checks every received word against per-node queues
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module mesh_tb;

    localparam int TIMEOUT = 2000;

    logic clock;
    logic rst;
    logic block_all_paths;
    mesh_pkg::cfg_t cfg [mesh_pkg::NUM_NODES];
    mesh_pkg::node_mask_t processor_ready;
    mesh_pkg::flit_t recv [mesh_pkg::NUM_NODES];
    // words owed to each destination, oldest first
    mesh_pkg::word_t exp_q [mesh_pkg::NUM_NODES][$];
    int seed;

    mesh_top uut (
        .clock(clock), .rst(rst), .cfg(cfg), .block_all_paths(block_all_paths),
        .processor_ready(processor_ready), .recv(recv)
    );

    always #50 clock = ~clock;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_flit(input string name, input mesh_pkg::flit_t got,
                              input mesh_pkg::flit_t want);
        if (got !== want)
            report_failure($sformatf("Fail time=%0t %s got %h expected %h",
                                     $time, name, got, want));
    endtask

    task automatic check_mask(input string name, input mesh_pkg::node_mask_t got,
                              input mesh_pkg::node_mask_t want);
        if (got !== want)
            report_failure($sformatf("Fail time=%0t %s got %b expected %b",
                                     $time, name, got, want));
    endtask

    // inputs change a little after the rising edge
    task automatic next_cycle();
        @(posedge clock);
        #5;
    endtask

    function automatic mesh_pkg::len_t random_len();
        return mesh_pkg::len_t'(1 + ({$random(seed)} % 255));
    endfunction

    function automatic logic queues_empty();
        logic empty;
        empty = 1'b1;
        for (int n = 0; n < mesh_pkg::NUM_NODES; n++)
            if (exp_q[n].size() != 0)
                empty = 1'b0;
        return empty;
    endfunction

    // source in 7:6, sequence mod 64 in 5:0
    task automatic expect_burst(input mesh_pkg::node_t src, input mesh_pkg::node_t dst,
                                input mesh_pkg::len_t len);
        for (int i = 0; i < int'(len); i++)
            exp_q[dst].push_back({src, i[5:0]});
    endtask

    task automatic start_cfg(input mesh_pkg::node_t src, input mesh_pkg::node_t dst,
                             input mesh_pkg::len_t len);
        cfg[src].request = 1'b1;
        cfg[src].dest = dst;
        cfg[src].len = len;
    endtask

    task automatic burst(input mesh_pkg::node_t src, input mesh_pkg::node_t dst);
        mesh_pkg::len_t len;
        len = random_len();
        expect_burst(src, dst, len);
        start_cfg(src, dst, len);
    endtask

    task automatic clear_cfg();
        for (int n = 0; n < mesh_pkg::NUM_NODES; n++)
            cfg[n] = '0;
    endtask

    task automatic wait_ready(input mesh_pkg::node_mask_t mask, input string what);
        int cycles;
        cycles = 0;
        while ((processor_ready & mask) != mask)
        begin
            if (cycles == TIMEOUT)
                report_failure($sformatf("timeout, %s never came back", what));
            else
            begin
                next_cycle();
                cycles++;
            end
        end
    endtask

    task automatic wait_drained(input string what);
        int cycles;
        cycles = 0;
        while (!queues_empty())
        begin
            if (cycles == TIMEOUT)
                report_failure($sformatf("timeout, words of %s never arrived", what));
            else
            begin
                next_cycle();
                cycles++;
            end
        end
    endtask

    // sampled mid cycle, away from the edge
    always @(negedge clock)
    begin
        mesh_pkg::flit_t want;
        for (int n = 0; n < mesh_pkg::NUM_NODES; n++)
        begin
            if (recv[n].valid === 1'b1)
            begin
                if (exp_q[n].size() == 0)
                    report_failure($sformatf("node %0d received word %h that nobody sent",
                                             n, recv[n].data));
                else
                begin
                    want.valid = 1'b1;
                    want.data = exp_q[n].pop_front();
                    check_flit($sformatf("recv[%0d]", n), recv[n], want);
                end
            end
        end
    end

    task automatic test_reset_idle();
        repeat (20)
        begin
            check_mask("processor_ready", processor_ready, 4'b1111);
            next_cycle();
        end
    endtask

    task automatic test_one_burst(input mesh_pkg::node_t src, input mesh_pkg::node_t dst,
                                  input string what);
        burst(src, dst);
        next_cycle();
        clear_cfg();
        wait_ready(4'b1111, $sformatf("ready after %s", what));
        wait_drained(what);
    endtask

    task automatic test_four_bursts();
        burst(2'd0, 2'd1);
        burst(2'd1, 2'd0);
        burst(2'd2, 2'd3);
        burst(2'd3, 2'd2);
        next_cycle();
        clear_cfg();
        wait_ready(4'b1111, "ready after four bursts");
        wait_drained("four bursts");
    endtask

    task automatic test_blocked();
        mesh_pkg::len_t len;
        len = random_len();
        block_all_paths = 1'b1;
        start_cfg(2'd1, 2'd2, len);
        next_cycle();
        clear_cfg();
        // monitor flags any word, nothing is expected yet
        repeat (50)
        begin
            check_mask("processor_ready", processor_ready, 4'b1101);
            next_cycle();
        end
        expect_burst(2'd1, 2'd2, len);
        block_all_paths = 1'b0;
        wait_ready(4'b1111, "ready of node 1 after release");
        wait_drained("blocked burst 1 to 2");
    endtask

    task automatic test_contention();
        burst(2'd0, 2'd3);
        burst(2'd1, 2'd2);
        next_cycle();
        clear_cfg();
        wait_ready(4'b1111, "ready after crossing diagonals");
        wait_drained("crossing diagonals");
        // 2-0-1 holds the east link of node 0
        burst(2'd2, 2'd1);
        next_cycle();
        clear_cfg();
        // asks one cycle behind, while that route is still held
        burst(2'd0, 2'd3);
        next_cycle();
        clear_cfg();
        wait_ready(4'b1111, "ready after diagonal beside busy link");
        wait_drained("diagonal beside busy link");
    endtask

    initial
    begin
        seed = 10;
        clock = 1'b0;
        rst = 1'b1;
        block_all_paths = 1'b0;
        clear_cfg();
        repeat (10) @(posedge clock);
        #5;
        rst = 1'b0;
        test_reset_idle();
        test_one_burst(2'd0, 2'd3, "burst 0 to 3");
        test_one_burst(2'd2, 2'd2, "self transfer at node 2");
        test_four_bursts();
        test_blocked();
        test_contention();
        if (queues_empty())
        begin
            $display("RESULT: PASS");
            $finish;
        end
        else
            report_failure("expected words still outstanding at the end");
    end

endmodule

// ==== src/mesh_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 2x2 mesh with central route allocation
//     2 - 3
//     |   |
//     0 - 1
// one unit per node, cfg and recv indexed by node
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module mesh_top (
    input  logic                 clock,
    input  logic                 rst,
    input  mesh_pkg::cfg_t       cfg [mesh_pkg::NUM_NODES],
    input  logic                 block_all_paths,
    output mesh_pkg::node_mask_t processor_ready,
    output mesh_pkg::flit_t      recv [mesh_pkg::NUM_NODES]
);

    mesh_pkg::flit_t r_in [mesh_pkg::NUM_NODES][mesh_pkg::NUM_OUTS];
    mesh_pkg::flit_t r_out [mesh_pkg::NUM_NODES][mesh_pkg::NUM_OUTS];
    mesh_pkg::route_req_t reqs [mesh_pkg::NUM_NODES];
    mesh_pkg::route_plan_t plans [mesh_pkg::NUM_NODES];
    mesh_pkg::router_sel_t selects [mesh_pkg::NUM_NODES];
    mesh_pkg::out_mask_t free [mesh_pkg::NUM_NODES];
    mesh_pkg::node_mask_t grant;
    mesh_pkg::node_mask_t found;
    mesh_pkg::node_mask_t response;
    mesh_pkg::node_mask_t done;
    logic grant_valid;

    for (genvar n = 0; n < mesh_pkg::NUM_NODES; n++)
    begin : g_node
        // links, edge inputs tied to an invalid flit
        if (n < 2)
        begin : g_low
            assign r_in[n][mesh_pkg::OUT_NORTH] = r_out[n + 2][mesh_pkg::OUT_SOUTH];
            assign r_in[n][mesh_pkg::OUT_SOUTH] = '0;
        end
        else
        begin : g_high
            assign r_in[n][mesh_pkg::OUT_NORTH] = '0;
            assign r_in[n][mesh_pkg::OUT_SOUTH] = r_out[n - 2][mesh_pkg::OUT_NORTH];
        end
        if (n % 2 == 0)
        begin : g_left
            assign r_in[n][mesh_pkg::OUT_EAST] = r_out[n + 1][mesh_pkg::OUT_WEST];
            assign r_in[n][mesh_pkg::OUT_WEST] = '0;
        end
        else
        begin : g_right
            assign r_in[n][mesh_pkg::OUT_EAST] = '0;
            assign r_in[n][mesh_pkg::OUT_WEST] = r_out[n - 1][mesh_pkg::OUT_EAST];
        end

        processing_unit #(.node_id(mesh_pkg::node_t'(n))) u_pu (
            .clock(clock), .rst(rst), .cfg(cfg[n]), .response(response[n]),
            .from_router(r_out[n][mesh_pkg::OUT_PROC]),
            .to_router(r_in[n][mesh_pkg::OUT_PROC]), .req(reqs[n]), .done(done[n]),
            .ready(processor_ready[n]), .recv(recv[n])
        );

        mesh_router u_router (
            .clock(clock), .rst(rst), .sel(selects[n]),
            .in_flits(r_in[n]), .out_flits(r_out[n])
        );
    end

    path_finder u_finder (.reqs(reqs), .free(free), .found(found), .plans(plans));

    request_arbiter u_arbiter (
        .clock(clock), .rst(rst), .reqs(reqs), .grant(grant), .grant_valid(grant_valid)
    );

    path_allocator u_alloc (
        .clock(clock), .rst(rst), .grant(grant), .grant_valid(grant_valid),
        .found(found), .plans(plans), .block_all_paths(block_all_paths), .done(done),
        .selects(selects), .free(free), .response(response)
    );

endmodule

// ==== src/processing_unit.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// processing unit at one mesh node
// takes a burst config, asks for a route, sends the words,
// waits for the mesh to drain and reports what arrives
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module processing_unit #(
    parameter mesh_pkg::node_t node_id = 2'd0
) (
    input  logic                 clock,
    input  logic                 rst,
    input  mesh_pkg::cfg_t       cfg,
    input  logic                 response,
    input  mesh_pkg::flit_t      from_router,
    output mesh_pkg::flit_t      to_router,
    output mesh_pkg::route_req_t req,
    output logic                 done,
    output logic                 ready,
    output mesh_pkg::flit_t      recv
);

    mesh_pkg::pu_state_t state;
    // burst sequence in SEND, drain cycles in DRAIN
    mesh_pkg::len_t cnt;
    mesh_pkg::node_t dest_q;
    mesh_pkg::len_t len_q;

    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            state <= mesh_pkg::IDLE;
            cnt <= '0;
        end
        else
        begin
            case (state)
                mesh_pkg::IDLE:
                    if (cfg.request)
                    begin
                        state <= mesh_pkg::REQUEST;
                        cnt <= '0;
                    end
                mesh_pkg::REQUEST:
                    if (response)
                        state <= mesh_pkg::SEND;
                mesh_pkg::SEND:
                    if (cnt == mesh_pkg::len_t'(len_q - 8'd1))
                    begin
                        state <= mesh_pkg::DRAIN;
                        cnt <= '0;
                    end
                    else
                        cnt <= cnt + 8'd1;
                default:
                    if (done)
                        state <= mesh_pkg::IDLE;
                    else
                        cnt <= cnt + 8'd1;
            endcase
        end
    end

    // burst config, only taken while idle
    always_ff @(posedge clock)
    begin
        if (state == mesh_pkg::IDLE && cfg.request)
        begin
            dest_q <= cfg.dest;
            len_q <= cfg.len;
        end
    end

    always_ff @(posedge clock)
    begin
        if (rst)
            recv.valid <= 1'b0;
        else
            recv <= from_router;
    end

    // request drops in the response cycle so it is not granted twice
    assign req.active = (state == mesh_pkg::REQUEST) && !response;
    assign req.dest = dest_q;
    assign ready = state == mesh_pkg::IDLE;
    assign done = (state == mesh_pkg::DRAIN) && (cnt == mesh_pkg::len_t'(mesh_pkg::MAX_HOPS - 1));
    assign to_router.valid = state == mesh_pkg::SEND;
    assign to_router.data = {node_id, cnt[5:0]};

endmodule

// ==== src/mesh_router.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// five port crossbar, one register per output
// each hop through a router costs one cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module mesh_router (
    input  logic                  clock,
    input  logic                  rst,
    input  mesh_pkg::router_sel_t sel,
    input  mesh_pkg::flit_t       in_flits [mesh_pkg::NUM_OUTS],
    output mesh_pkg::flit_t       out_flits [mesh_pkg::NUM_OUTS]
);

    // selects by output index
    mesh_pkg::port_sel_t osel [mesh_pkg::NUM_OUTS];

    assign osel[mesh_pkg::OUT_NORTH] = sel.north;
    assign osel[mesh_pkg::OUT_SOUTH] = sel.south;
    assign osel[mesh_pkg::OUT_EAST] = sel.east;
    assign osel[mesh_pkg::OUT_WEST] = sel.west;
    assign osel[mesh_pkg::OUT_PROC] = sel.proc;

    always_ff @(posedge clock)
    begin
        for (int o = 0; o < mesh_pkg::NUM_OUTS; o++)
        begin
            if (rst)
                out_flits[o].valid <= 1'b0;
            // unused output, or a code past the last port
            else if (osel[o] == mesh_pkg::SEL_NONE || osel[o] > mesh_pkg::SEL_PROC)
                out_flits[o] <= '0;
            // code minus one is the input index
            else
                out_flits[o] <= in_flits[osel[o] - 3'd1];
        end
    end

endmodule

// ==== src/path_allocator.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// commits granted routes and holds them per source
// drives router selects and free masks, answers the unit
// one cycle after commit, drops the route on done
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module path_allocator (
    input  logic                  clock,
    input  logic                  rst,
    input  mesh_pkg::node_mask_t  grant,
    input  logic                  grant_valid,
    input  mesh_pkg::node_mask_t  found,
    input  mesh_pkg::route_plan_t plans [mesh_pkg::NUM_NODES],
    input  logic                  block_all_paths,
    input  mesh_pkg::node_mask_t  done,
    output mesh_pkg::router_sel_t selects [mesh_pkg::NUM_NODES],
    output mesh_pkg::out_mask_t   free [mesh_pkg::NUM_NODES],
    output mesh_pkg::node_mask_t  response
);

    // route owned by each source
    mesh_pkg::route_plan_t held [mesh_pkg::NUM_NODES];
    mesh_pkg::route_plan_t merged;
    logic commit;

    // grant is one hot, so this is the winner's found bit
    assign commit = grant_valid && |(grant & found) && !block_all_paths;

    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            for (int s = 0; s < mesh_pkg::NUM_NODES; s++)
                held[s] <= '0;
            response <= '0;
        end
        else
        begin
            for (int s = 0; s < mesh_pkg::NUM_NODES; s++)
            begin
                if (done[s])
                    held[s] <= '0;
                else if (commit && grant[s])
                    held[s] <= held[s] | plans[s];
            end
            // single cycle answer to the winner
            response <= commit ? grant : '0;
        end
    end

    // held routes never share an output, so OR is safe
    always_comb
    begin
        merged = '0;
        for (int s = 0; s < mesh_pkg::NUM_NODES; s++)
            merged = merged | held[s];
    end

    for (genvar n = 0; n < mesh_pkg::NUM_NODES; n++)
    begin : g_node
        assign selects[n] = merged[n];
        // output free while nothing selects into it
        assign free[n][mesh_pkg::OUT_NORTH] = merged[n].north == mesh_pkg::SEL_NONE;
        assign free[n][mesh_pkg::OUT_SOUTH] = merged[n].south == mesh_pkg::SEL_NONE;
        assign free[n][mesh_pkg::OUT_EAST] = merged[n].east == mesh_pkg::SEL_NONE;
        assign free[n][mesh_pkg::OUT_WEST] = merged[n].west == mesh_pkg::SEL_NONE;
        assign free[n][mesh_pkg::OUT_PROC] = merged[n].proc == mesh_pkg::SEL_NONE;
    end

endmodule

// ==== src/request_arbiter.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// rotating priority among units asking for a route
// grant is combinational, pointer steps past each winner
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module request_arbiter (
    input  logic                 clock,
    input  logic                 rst,
    input  mesh_pkg::route_req_t reqs [mesh_pkg::NUM_NODES],
    output mesh_pkg::node_mask_t grant,
    output logic                 grant_valid
);

    // node with first priority this cycle
    mesh_pkg::node_t ptr;
    mesh_pkg::node_t win;

    always_comb
    begin
        mesh_pkg::node_t idx;
        grant = '0;
        win = ptr;
        // walk from the far end, nearest request is written last
        for (int i = mesh_pkg::NUM_NODES - 1; i >= 0; i--)
        begin
            idx = ptr + mesh_pkg::node_t'(i);
            if (reqs[idx].active)
            begin
                grant = mesh_pkg::node_mask_t'(1) << idx;
                win = idx;
            end
        end
    end

    assign grant_valid = |grant;

    // blocked winner still loses its turn
    always_ff @(posedge clock)
    begin
        if (rst)
            ptr <= '0;
        else if (grant_valid)
            ptr <= win + 2'd1;
    end

endmodule

// ==== src/path_finder.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// combinational route search for every source
// tries the candidate routes in order against the free outputs
// and returns the selects of the first one that fits
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module path_finder (
    input  mesh_pkg::route_req_t  reqs [mesh_pkg::NUM_NODES],
    input  mesh_pkg::out_mask_t   free [mesh_pkg::NUM_NODES],
    output mesh_pkg::node_mask_t  found,
    output mesh_pkg::route_plan_t plans [mesh_pkg::NUM_NODES]
);

    // output of router a facing neighbour b
    function automatic int dir_out(input mesh_pkg::node_t a, input mesh_pkg::node_t b);
        if ((a ^ b) == 2'd1)
            return a[0] ? mesh_pkg::OUT_WEST : mesh_pkg::OUT_EAST;
        return a[1] ? mesh_pkg::OUT_SOUTH : mesh_pkg::OUT_NORTH;
    endfunction

    function automatic mesh_pkg::router_sel_t set_out(
        input mesh_pkg::router_sel_t r,
        input int o,
        input mesh_pkg::port_sel_t s
    );
        mesh_pkg::router_sel_t v;
        v = r;
        case (o)
            mesh_pkg::OUT_NORTH: v.north = s;
            mesh_pkg::OUT_SOUTH: v.south = s;
            mesh_pkg::OUT_EAST:  v.east = s;
            mesh_pkg::OUT_WEST:  v.west = s;
            default:             v.proc = s;
        endcase
        return v;
    endfunction

    // build selects along p[0..hops], high when every output used is free
    function automatic logic try_path(
        input  mesh_pkg::node_t       p [4],
        input  int                    hops,
        input  mesh_pkg::out_mask_t   fr [mesh_pkg::NUM_NODES],
        output mesh_pkg::route_plan_t plan
    );
        logic ok;
        int o;
        mesh_pkg::port_sel_t src;
        ok = 1'b1;
        plan = '0;
        // first router takes the word from its own unit
        src = mesh_pkg::SEL_PROC;
        for (int i = 0; i < 3; i++)
        begin
            if (i < hops)
            begin
                o = dir_out(p[i], p[i + 1]);
                ok = ok & fr[p[i]][o];
                plan[p[i]] = set_out(plan[p[i]], o, src);
                // next router sees it on the port facing back
                src = mesh_pkg::port_sel_t'(dir_out(p[i + 1], p[i]) + 1);
            end
        end
        ok = ok & fr[p[hops]][mesh_pkg::OUT_PROC];
        plan[p[hops]] = set_out(plan[p[hops]], mesh_pkg::OUT_PROC, src);
        return ok;
    endfunction

    for (genvar s = 0; s < mesh_pkg::NUM_NODES; s++)
    begin : g_src
        mesh_pkg::node_t pa [4];
        mesh_pkg::node_t pb [4];
        mesh_pkg::node_t m;
        mesh_pkg::node_t o;
        mesh_pkg::route_plan_t plan_a;
        mesh_pkg::route_plan_t plan_b;
        logic ok_a;
        logic ok_b;
        int ha;
        int hb;

        always_comb
        begin
            // 1 flat neighbour, 2 vertical neighbour, 3 diagonal
            m = mesh_pkg::node_t'(s) ^ reqs[s].dest;
            // axis of the detour around the square
            o = (m == 2'd1) ? 2'd2 : 2'd1;
            // self, direct hop, or vertical first
            pa[0] = mesh_pkg::node_t'(s);
            pa[1] = (m == 2'd3) ? (mesh_pkg::node_t'(s) ^ 2'd2) : reqs[s].dest;
            pa[2] = reqs[s].dest;
            pa[3] = reqs[s].dest;
            ha = (m == 2'd0) ? 0 : ((m == 2'd3) ? 2 : 1);
            // three hop detour, or flat first
            pb[0] = mesh_pkg::node_t'(s);
            pb[1] = mesh_pkg::node_t'(s) ^ o;
            pb[2] = (m == 2'd3) ? reqs[s].dest : (reqs[s].dest ^ o);
            pb[3] = reqs[s].dest;
            hb = (m == 2'd3) ? 2 : 3;
            ok_a = try_path(pa, ha, free, plan_a);
            // self transfer has no second route
            ok_b = try_path(pb, hb, free, plan_b) && (m != 2'd0);
        end

        assign found[s] = reqs[s].active && (ok_a || ok_b);
        assign plans[s] = !found[s] ? '0 : (ok_a ? plan_a : plan_b);
    end

endmodule

// ==== src/mesh_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types and constants for the 2x2 mesh
// routers, units and the central allocator all refer here
// by scoped name
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package mesh_pkg;

    localparam int NUM_NODES = 4;
    // north, south, east, west, processor
    localparam int NUM_OUTS = 5;
    // drain cycles after a burst, longest route is four routers
    localparam int MAX_HOPS = 4;

    typedef logic [1:0] node_t;
    typedef logic [7:0] word_t;
    typedef logic [7:0] len_t;
    typedef logic [2:0] port_sel_t;
    typedef logic [NUM_NODES-1:0] node_mask_t;
    typedef logic [NUM_OUTS-1:0] out_mask_t;

    // select code names the input feeding an output
    // code is input index plus one
    localparam port_sel_t SEL_NONE = 3'd0;
    localparam port_sel_t SEL_NORTH = 3'd1;
    localparam port_sel_t SEL_SOUTH = 3'd2;
    localparam port_sel_t SEL_EAST = 3'd3;
    localparam port_sel_t SEL_WEST = 3'd4;
    localparam port_sel_t SEL_PROC = 3'd5;

    // port indices, same for inputs and outputs
    localparam int OUT_NORTH = 0;
    localparam int OUT_SOUTH = 1;
    localparam int OUT_EAST = 2;
    localparam int OUT_WEST = 3;
    localparam int OUT_PROC = 4;

    // data word is source node in 7:6, sequence mod 64 in 5:0
    typedef struct packed {logic valid; word_t data;} flit_t;
    typedef struct packed {logic request; node_t dest; len_t len;} cfg_t;
    typedef struct packed {logic active; node_t dest;} route_req_t;
    typedef struct packed {
        port_sel_t north;
        port_sel_t south;
        port_sel_t east;
        port_sel_t west;
        port_sel_t proc;
    } router_sel_t;
    // one set of selects per router, indexed by node
    typedef router_sel_t [NUM_NODES-1:0] route_plan_t;

    typedef enum logic [1:0] {IDLE, REQUEST, SEND, DRAIN} pu_state_t;

endpackage
